// File: design/sram_cfg_pkg.sv
package sram_cfg_pkg;

  // *************************************************************************
  // SRAM pin widths
  // *************************************************************************

  localparam int sram_addr_width = 16;  // 64K locations.
  localparam int sram_data_width = 8;   // One byte per access.
  localparam int sram_strb_width = 1;   // One strobe per byte.

  // *************************************************************************
  // Command tag and response FIFO
  // *************************************************************************

  localparam int sram_meta_width = 4;   // Tag handed back with each response.

  localparam int resp_depth = 4;
  localparam int resp_cnt_width = 3;    // Holds 0 up to resp_depth.

  // Pointers index the entries, one bit less than the counters.
  localparam int resp_ptr_width = resp_cnt_width - 1;

endpackage

// File: design/sram_op_pkg.sv
package sram_op_pkg;

  // *************************************************************************
  // Access opcode
  // *************************************************************************

  typedef enum logic {
    sram_op_read  = 1'b0,
    sram_op_write = 1'b1
  } sram_op_e;

  // *************************************************************************
  // Sequencer states
  // *************************************************************************

  // Every access is one active cycle followed by one recovery cycle.
  typedef enum logic [1:0] {
    st_idle    = 2'd0,
    st_write   = 2'd1,  // we_n low when the strobe is set.
    st_read    = 2'd2,  // oe_n low, data sampled at the end.
    st_recover = 2'd3   // Pins released, next command may transfer.
  } io_state_e;

endpackage

// File: design/sram_if.sv
// Command path from the skid buffer to the sequencer.
interface sram_cmd_if;

  logic                                       valid;
  logic                                       ready;
  sram_op_pkg::sram_op_e                      op;
  logic [sram_cfg_pkg::sram_addr_width-1:0]   addr;
  logic [sram_cfg_pkg::sram_data_width-1:0]   wr_data;
  logic [sram_cfg_pkg::sram_strb_width-1:0]   wr_strb;
  logic [sram_cfg_pkg::sram_meta_width-1:0]   meta;
  logic                                       last;

  modport src (output valid, op, addr, wr_data, wr_strb, meta, last, input ready);
  modport dst (input valid, op, addr, wr_data, wr_strb, meta, last, output ready);

endinterface

// Response path from the sequencer to the response FIFO.
interface sram_resp_if;

  logic                                       grant;    // A FIFO slot is free.
  logic                                       reserve;  // Claims a slot at transfer.
  logic                                       push;
  logic [sram_cfg_pkg::sram_meta_width-1:0]   meta;
  logic                                       last;
  logic [sram_cfg_pkg::sram_data_width-1:0]   rd_data;

  modport ctrl (input grant, output reserve, push, meta, last, rd_data);
  modport fifo (output grant, input reserve, push, meta, last, rd_data);

endinterface

// File: design/sram_cmd_skid.sv
module sram_cmd_skid (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     cmd_valid,
  input  logic [sram_cfg_pkg::sram_addr_width-1:0] cmd_addr,
  input  logic [sram_cfg_pkg::sram_meta_width-1:0] cmd_meta,
  input  logic                                     cmd_last,
  input  logic                                     cmd_wr_en,
  input  logic [sram_cfg_pkg::sram_data_width-1:0] cmd_wr_data,
  input  logic [sram_cfg_pkg::sram_strb_width-1:0] cmd_wr_strb,
  output logic                                     cmd_ready,
  sram_cmd_if.src                                  cmd
);

  logic                                     skid_valid;
  sram_op_pkg::sram_op_e                    skid_op;
  logic [sram_cfg_pkg::sram_addr_width-1:0] skid_addr;
  logic [sram_cfg_pkg::sram_data_width-1:0] skid_wr_data;
  logic [sram_cfg_pkg::sram_strb_width-1:0] skid_wr_strb;
  logic [sram_cfg_pkg::sram_meta_width-1:0] skid_meta;
  logic                                     skid_last;

  sram_op_pkg::sram_op_e                    in_op;
  logic                                     in_fire;
  logic                                     out_free;

  assign in_op    = cmd_wr_en ? sram_op_pkg::sram_op_write : sram_op_pkg::sram_op_read;
  assign in_fire  = cmd_valid && cmd_ready;
  assign out_free = !cmd.valid || cmd.ready;  // Output entry empties at this edge.

  // The port only closes once the second entry is occupied.
  assign cmd_ready = !skid_valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cmd.valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_free) begin
      cmd.valid  <= skid_valid || in_fire;
      skid_valid <= 1'b0;  // Drained into the output entry.
    end else if (in_fire) begin
      skid_valid <= 1'b1;  // Output stalled, park the new command.
    end
  end

  always_ff @(posedge clk) begin
    if (out_free) begin
      if (skid_valid) begin
        cmd.op      <= skid_op;
        cmd.addr    <= skid_addr;
        cmd.wr_data <= skid_wr_data;
        cmd.wr_strb <= skid_wr_strb;
        cmd.meta    <= skid_meta;
        cmd.last    <= skid_last;
      end else begin
        cmd.op      <= in_op;
        cmd.addr    <= cmd_addr;
        cmd.wr_data <= cmd_wr_data;
        cmd.wr_strb <= cmd_wr_strb;
        cmd.meta    <= cmd_meta;
        cmd.last    <= cmd_last;
      end
    end else if (in_fire) begin
      skid_op      <= in_op;
      skid_addr    <= cmd_addr;
      skid_wr_data <= cmd_wr_data;
      skid_wr_strb <= cmd_wr_strb;
      skid_meta    <= cmd_meta;
      skid_last    <= cmd_last;
    end
  end

endmodule

// File: design/sram_io_ctrl.sv
module sram_io_ctrl (
  input  logic                                     clk,
  input  logic                                     rst_n,
  sram_cmd_if.dst                                  cmd,
  sram_resp_if.ctrl                                resp,
  output logic [sram_cfg_pkg::sram_addr_width-1:0] sram_addr,
  output logic [sram_cfg_pkg::sram_data_width-1:0] sram_wr_data,
  input  logic [sram_cfg_pkg::sram_data_width-1:0] sram_rd_data,
  output logic                                     sram_data_oe,
  output logic                                     sram_we_n,
  output logic                                     sram_oe_n,
  output logic                                     sram_ce_n
);

  sram_op_pkg::io_state_e                   state;
  logic                                     accept_ok;
  logic                                     cmd_fire;
  logic                                     cmd_is_write;
  logic [sram_cfg_pkg::sram_meta_width-1:0] meta_q;
  logic                                     last_q;

  // *************************************************************************
  // Command acceptance
  // *************************************************************************

  // Accept only outside an active cycle and only with a FIFO slot free.
  assign accept_ok = (state == sram_op_pkg::st_idle) ||
                     (state == sram_op_pkg::st_recover);

  assign cmd.ready    = accept_ok && resp.grant;
  assign cmd_fire     = cmd.valid && cmd.ready;
  assign cmd_is_write = (cmd.op == sram_op_pkg::sram_op_write);

  // *************************************************************************
  // Access FSM and pin control
  // *************************************************************************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state        <= sram_op_pkg::st_idle;
      sram_we_n    <= 1'b1;
      sram_oe_n    <= 1'b1;
      sram_data_oe <= 1'b0;
    end else begin
      sram_we_n    <= 1'b1;
      sram_oe_n    <= 1'b1;
      sram_data_oe <= (state == sram_op_pkg::st_write);  // Hold the bus into recovery.
      case (state)
        sram_op_pkg::st_idle,
        sram_op_pkg::st_recover: begin
          if (cmd_fire && cmd_is_write) begin
            state        <= sram_op_pkg::st_write;
            sram_we_n    <= !(|cmd.wr_strb);  // A cleared strobe leaves memory untouched.
            sram_data_oe <= 1'b1;
          end else if (cmd_fire) begin
            state     <= sram_op_pkg::st_read;
            sram_oe_n <= 1'b0;
          end else begin
            state <= sram_op_pkg::st_idle;
          end
        end
        sram_op_pkg::st_write,
        sram_op_pkg::st_read: begin
          state <= sram_op_pkg::st_recover;
        end
        default: begin
          state <= sram_op_pkg::st_idle;
        end
      endcase
    end
  end

  // Address and data only move on a transfer, so they are steady while we_n is low.
  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      sram_addr    <= cmd.addr;
      sram_wr_data <= cmd.wr_data;
      meta_q       <= cmd.meta;
      last_q       <= cmd.last;
    end
  end

  // Power-down is not supported, the chip stays selected.
  assign sram_ce_n = 1'b0;

  // *************************************************************************
  // Response side
  // *************************************************************************

  assign resp.reserve = cmd_fire;

  // The FIFO stores at the end of the active cycle, which samples the read data.
  assign resp.push = (state == sram_op_pkg::st_write) ||
                     (state == sram_op_pkg::st_read);
  assign resp.meta = meta_q;
  assign resp.last = last_q;
  assign resp.rd_data = (state == sram_op_pkg::st_read) ? sram_rd_data : '0;

endmodule

// File: design/sram_resp_fifo.sv
module sram_resp_fifo (
  input  logic                                     clk,
  input  logic                                     rst_n,
  sram_resp_if.fifo                                resp,
  output logic                                     resp_valid,
  output logic [sram_cfg_pkg::sram_meta_width-1:0] resp_meta,
  output logic                                     resp_last,
  output logic [sram_cfg_pkg::sram_data_width-1:0] resp_rd_data,
  input  logic                                     resp_ready
);

  logic [sram_cfg_pkg::sram_meta_width-1:0] meta_mem [sram_cfg_pkg::resp_depth];
  logic                                     last_mem [sram_cfg_pkg::resp_depth];
  logic [sram_cfg_pkg::sram_data_width-1:0] data_mem [sram_cfg_pkg::resp_depth];

  logic [sram_cfg_pkg::resp_ptr_width-1:0]  wr_ptr;
  logic [sram_cfg_pkg::resp_ptr_width-1:0]  rd_ptr;
  logic [sram_cfg_pkg::resp_cnt_width-1:0]  count;  // Stored entries.
  logic [sram_cfg_pkg::resp_cnt_width-1:0]  rsv;    // Accesses in flight.
  logic [sram_cfg_pkg::resp_cnt_width:0]    slots_used;
  logic                                     pop;

  assign slots_used = {1'b0, count} + {1'b0, rsv};
  assign resp.grant = slots_used < (sram_cfg_pkg::resp_cnt_width + 1)'(sram_cfg_pkg::resp_depth);

  assign resp_valid   = (count != '0);
  assign resp_meta    = meta_mem[rd_ptr];
  assign resp_last    = last_mem[rd_ptr];
  assign resp_rd_data = data_mem[rd_ptr];
  assign pop          = resp_valid && resp_ready;

  always_ff @(posedge clk) begin
    if (resp.push) begin
      meta_mem[wr_ptr] <= resp.meta;
      last_mem[wr_ptr] <= resp.last;
      data_mem[wr_ptr] <= resp.rd_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      rsv    <= '0;
    end else begin
      if (resp.push) begin
        wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two, so it wraps.
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      case ({resp.push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // A push and a pop cancel.
      endcase

      // A push converts the oldest reservation into a stored entry.
      case ({resp.reserve, resp.push})
        2'b10:   rsv <= rsv + 1'b1;
        2'b01:   rsv <= rsv - 1'b1;
        default: rsv <= rsv;
      endcase
    end
  end

endmodule

// File: design/sram_subsys_top.sv
module sram_subsys_top (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     cmd_valid,
  output logic                                     cmd_ready,
  input  logic [sram_cfg_pkg::sram_addr_width-1:0] cmd_addr,
  input  logic [sram_cfg_pkg::sram_meta_width-1:0] cmd_meta,
  input  logic                                     cmd_last,
  input  logic                                     cmd_wr_en,
  input  logic [sram_cfg_pkg::sram_data_width-1:0] cmd_wr_data,
  input  logic [sram_cfg_pkg::sram_strb_width-1:0] cmd_wr_strb,
  output logic                                     resp_valid,
  input  logic                                     resp_ready,
  output logic [sram_cfg_pkg::sram_meta_width-1:0] resp_meta,
  output logic                                     resp_last,
  output logic [sram_cfg_pkg::sram_data_width-1:0] resp_rd_data,
  output logic [sram_cfg_pkg::sram_addr_width-1:0] sram_addr,
  inout  wire  [sram_cfg_pkg::sram_data_width-1:0] sram_data,
  output logic                                     sram_we_n,
  output logic                                     sram_oe_n,
  output logic                                     sram_ce_n
);

  logic [sram_cfg_pkg::sram_data_width-1:0] sram_wr_data;
  logic [sram_cfg_pkg::sram_data_width-1:0] sram_rd_data;
  logic                                     sram_data_oe;

  sram_cmd_if  cmd_bus ();
  sram_resp_if resp_bus ();

  sram_cmd_skid skid0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid   (cmd_valid),
    .cmd_addr    (cmd_addr),
    .cmd_meta    (cmd_meta),
    .cmd_last    (cmd_last),
    .cmd_wr_en   (cmd_wr_en),
    .cmd_wr_data (cmd_wr_data),
    .cmd_wr_strb (cmd_wr_strb),
    .cmd_ready   (cmd_ready),
    .cmd         (cmd_bus.src)
  );

  sram_io_ctrl ctrl0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd          (cmd_bus.dst),
    .resp         (resp_bus.ctrl),
    .sram_addr    (sram_addr),
    .sram_wr_data (sram_wr_data),
    .sram_rd_data (sram_rd_data),
    .sram_data_oe (sram_data_oe),
    .sram_we_n    (sram_we_n),
    .sram_oe_n    (sram_oe_n),
    .sram_ce_n    (sram_ce_n)
  );

  sram_resp_fifo fifo0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .resp         (resp_bus.fifo),
    .resp_valid   (resp_valid),
    .resp_meta    (resp_meta),
    .resp_last    (resp_last),
    .resp_rd_data (resp_rd_data),
    .resp_ready   (resp_ready)
  );

  // Bidirectional data pins, released whenever no write is in progress.
  assign sram_data    = sram_data_oe ? sram_wr_data : 'z;
  assign sram_rd_data = sram_data;

endmodule

// File: sim/sram_model.sv
module sram_model (
  input  logic [sram_cfg_pkg::sram_addr_width-1:0] addr,
  inout  wire  [sram_cfg_pkg::sram_data_width-1:0] data,
  input  logic                                     we_n,
  input  logic                                     oe_n,
  input  logic                                     ce_n,
  output logic                                     unwritten_read
);

  logic [sram_cfg_pkg::sram_data_width-1:0] mem [1 << sram_cfg_pkg::sram_addr_width];
  bit                                       written [1 << sram_cfg_pkg::sram_addr_width];

  // The cell takes the bus value at the end of the write pulse.
  always @(posedge we_n) begin
    if (ce_n === 1'b0 && !$isunknown(addr)) begin
      mem[addr] = data;
      written[addr] = 1'b1;
    end
  end

  // Output enable drives the bus only while no write is going on.
  assign data = (ce_n === 1'b0 && oe_n === 1'b0 && we_n === 1'b1) ? mem[addr] : 'z;

  assign unwritten_read = (ce_n === 1'b0 && oe_n === 1'b0) && !written[addr];

endmodule

// File: sim/sram_checker.sv
module sram_checker (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic [7:0]                               cur_test,
  input  logic [sram_cfg_pkg::sram_data_width-1:0] exp_data,
  input  logic                                     cmd_valid,
  input  logic                                     cmd_ready,
  input  logic [sram_cfg_pkg::sram_meta_width-1:0] cmd_meta,
  input  logic                                     cmd_last,
  input  logic                                     cmd_wr_en,
  input  logic                                     resp_valid,
  input  logic                                     resp_ready,
  input  logic [sram_cfg_pkg::sram_meta_width-1:0] resp_meta,
  input  logic                                     resp_last,
  input  logic [sram_cfg_pkg::sram_data_width-1:0] resp_rd_data,
  input  logic                                     sram_ce_n,
  input  logic                                     sram_oe_n,
  input  logic                                     sram_we_n,
  input  logic                                     unwritten_read,
  output logic                                     drained,
  output int                                       pass_count,
  output int                                       fail_count
);

  typedef struct packed {
    logic [7:0]                               test;
    logic [sram_cfg_pkg::sram_meta_width-1:0] meta;
    logic                                     last;
    logic [sram_cfg_pkg::sram_data_width-1:0] data;
  } exp_t;

  exp_t exp_q[$];  // Expected responses in command order.
  bit   test_bad [16];
  int   pending = 0;
  int   cycle = 0;
  int   t5_start = 0;
  int   t5_writes = 0;
  int   t4_low_run = 0;
  bit   t4_stalled = 1'b0;
  bit   t1_done = 1'b0;
  bit   read_flagged = 1'b0;

  assign drained = (pending == 0);

  initial begin
    pass_count = 0;
    fail_count = 0;
  end

  task automatic finish_test(input logic [7:0] t);
    if (t == 8'd4 && !t4_stalled) begin
      $display("Test 4: cmd_ready never fell while responses were held back");
      test_bad[4] = 1'b1;
    end
    if (test_bad[t]) begin
      fail_count++;
      $display("Test %0d FAILED", t);
    end else begin
      pass_count++;
      $display("Test %0d passed", t);
    end
  endtask

  always @(posedge clk) begin
    exp_t e;
    if (rst_n) begin
      cycle++;

      // *********************************************************************
      // Idle state after reset
      // *********************************************************************
      if (cur_test == 8'd1) begin
        if (sram_ce_n !== 1'b0 || sram_oe_n !== 1'b1 || sram_we_n !== 1'b1 ||
            resp_valid !== 1'b0) begin
          $display("Test 1: SRAM pins or resp_valid not idle in cycle %0d", cycle);
          test_bad[1] = 1'b1;
        end
      end else if (!t1_done) begin
        t1_done = 1'b1;
        finish_test(8'd1);
      end

      if (unwritten_read === 1'b1 && !read_flagged) begin
        $display("Test %0d: SRAM read from an address that was never written", cur_test);
        read_flagged = 1'b1;
        test_bad[cur_test] = 1'b1;
      end

      // Only a full response FIFO keeps cmd_ready low for two cycles in a row.
      if (cur_test == 8'd4 && !cmd_ready) begin
        t4_low_run++;
        if (t4_low_run >= 2) begin
          t4_stalled = 1'b1;
        end
      end else begin
        t4_low_run = 0;
      end

      // *********************************************************************
      // Command and response handshakes
      // *********************************************************************
      if (cmd_valid && cmd_ready) begin
        exp_q.push_back('{test: cur_test, meta: cmd_meta, last: cmd_last, data: exp_data});
        if (cur_test == 8'd5 && cmd_wr_en) begin
          if (t5_writes == 0) begin
            t5_start = cycle;
          end
          t5_writes++;
          if (t5_writes == 16 && cycle - t5_start + 1 > 36) begin
            $display("Test 5: sixteen writes took %0d cycles to be accepted",
                     cycle - t5_start + 1);
            test_bad[5] = 1'b1;
          end
        end
      end

      if (resp_valid && resp_ready) begin
        if (exp_q.size() == 0) begin
          $display("Response with meta %h arrived with no command outstanding", resp_meta);
          fail_count++;
        end else begin
          e = exp_q.pop_front();
          if (resp_meta !== e.meta || resp_last !== e.last || resp_rd_data !== e.data) begin
            $display("Error test %0d expected meta=%h last=%b data=%h actual meta=%h last=%b data=%h",
                     e.test, e.meta, e.last, e.data, resp_meta, resp_last, resp_rd_data);
            test_bad[e.test] = 1'b1;
          end
          if (e.last) begin
            finish_test(e.test);  // The test's final response.
          end
        end
      end

      pending <= pending + (cmd_valid && cmd_ready) - (resp_valid && resp_ready);
    end
  end

endmodule

// File: sim/sram_properties.sv
module sram_properties (
  input logic                                     clk,
  input logic                                     rst_n,
  input sram_op_pkg::io_state_e                   state,
  input logic [sram_cfg_pkg::sram_addr_width-1:0] sram_addr,
  input logic [sram_cfg_pkg::sram_data_width-1:0] sram_wr_data,
  input logic                                     sram_data_oe,
  input logic                                     sram_we_n,
  input logic                                     sram_oe_n,
  input logic                                     sram_ce_n,
  input logic                                     grant
);

  int fail_count = 0;

  pins_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    sram_we_n || sram_oe_n)
    else begin
      $error("we_n and oe_n are low together");
      fail_count++;
    end

  // Address and data hold through the rise of we_n, bus still driven.
  write_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !sram_we_n |=> $stable(sram_addr) && $stable(sram_wr_data) && sram_data_oe)
    else begin
      $error("address or write data moved around the we_n pulse");
      fail_count++;
    end

  // With no slot left in the response FIFO no new access may start.
  access_needs_grant: assert property (@(posedge clk) disable iff (!rst_n)
    !grant |=> state != sram_op_pkg::st_write && state != sram_op_pkg::st_read)
    else begin
      $error("access started without a response slot");
      fail_count++;
    end

  reset_values: assert property (@(posedge clk)
    $rose(rst_n) |-> !sram_ce_n && sram_oe_n && sram_we_n && !sram_data_oe &&
                     state == sram_op_pkg::st_idle)
    else begin
      $error("SRAM pins not at their reset values");
      fail_count++;
    end

endmodule

bind sram_io_ctrl sram_properties props0 (
  .clk          (clk),
  .rst_n        (rst_n),
  .state        (state),
  .sram_addr    (sram_addr),
  .sram_wr_data (sram_wr_data),
  .sram_data_oe (sram_data_oe),
  .sram_we_n    (sram_we_n),
  .sram_oe_n    (sram_oe_n),
  .sram_ce_n    (sram_ce_n),
  .grant        (resp.grant)
);

// File: sim/sram_tb.sv
module sram_tb;

  localparam int seed = 2769;
  localparam int max_cmds = 64;
  localparam int timeout_margin = 100;

  logic                                     clk;
  logic                                     rst_n;
  logic                                     cmd_valid;
  logic                                     cmd_ready;
  logic [sram_cfg_pkg::sram_addr_width-1:0] cmd_addr;
  logic [sram_cfg_pkg::sram_meta_width-1:0] cmd_meta;
  logic                                     cmd_last;
  logic                                     cmd_wr_en;
  logic [sram_cfg_pkg::sram_data_width-1:0] cmd_wr_data;
  logic [sram_cfg_pkg::sram_strb_width-1:0] cmd_wr_strb;
  logic                                     resp_valid;
  logic                                     resp_ready;
  logic [sram_cfg_pkg::sram_meta_width-1:0] resp_meta;
  logic                                     resp_last;
  logic [sram_cfg_pkg::sram_data_width-1:0] resp_rd_data;
  logic [sram_cfg_pkg::sram_addr_width-1:0] sram_addr;
  wire  [sram_cfg_pkg::sram_data_width-1:0] sram_data;
  logic                                     sram_we_n;
  logic                                     sram_oe_n;
  logic                                     sram_ce_n;
  logic                                     unwritten_read;
  logic [7:0]                               cur_test;
  logic [sram_cfg_pkg::sram_data_width-1:0] exp_data;
  logic                                     drained;
  int                                       pass_count;
  int                                       fail_count;
  logic [31:0]                              rng;
  int                                       n_cmds = 0;
  int                                       cycle_limit = 0;

  // One entry per command line of the stimulus file.
  logic [31:0] stim_test [max_cmds];
  logic [31:0] stim_op   [max_cmds];
  logic [31:0] stim_addr [max_cmds];
  logic [31:0] stim_data [max_cmds];
  logic [31:0] stim_strb [max_cmds];
  logic [31:0] stim_meta [max_cmds];
  logic [31:0] stim_last [max_cmds];
  logic [31:0] stim_exp  [max_cmds];

  sram_subsys_top dut0 (
    .clk (clk), .rst_n (rst_n),
    .cmd_valid (cmd_valid), .cmd_ready (cmd_ready), .cmd_addr (cmd_addr),
    .cmd_meta (cmd_meta), .cmd_last (cmd_last), .cmd_wr_en (cmd_wr_en),
    .cmd_wr_data (cmd_wr_data), .cmd_wr_strb (cmd_wr_strb),
    .resp_valid (resp_valid), .resp_ready (resp_ready), .resp_meta (resp_meta),
    .resp_last (resp_last), .resp_rd_data (resp_rd_data),
    .sram_addr (sram_addr), .sram_data (sram_data), .sram_we_n (sram_we_n),
    .sram_oe_n (sram_oe_n), .sram_ce_n (sram_ce_n)
  );

  sram_model model0 (
    .addr (sram_addr), .data (sram_data), .we_n (sram_we_n), .oe_n (sram_oe_n),
    .ce_n (sram_ce_n), .unwritten_read (unwritten_read)
  );

  sram_checker checker0 (
    .clk (clk), .rst_n (rst_n), .cur_test (cur_test), .exp_data (exp_data),
    .cmd_valid (cmd_valid), .cmd_ready (cmd_ready), .cmd_meta (cmd_meta),
    .cmd_last (cmd_last), .cmd_wr_en (cmd_wr_en),
    .resp_valid (resp_valid), .resp_ready (resp_ready), .resp_meta (resp_meta),
    .resp_last (resp_last), .resp_rd_data (resp_rd_data),
    .sram_ce_n (sram_ce_n), .sram_oe_n (sram_oe_n), .sram_we_n (sram_we_n),
    .unwritten_read (unwritten_read), .drained (drained),
    .pass_count (pass_count), .fail_count (fail_count)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Responses are held back three cycles in four during test 4.
  always @(posedge clk) begin
    if (cur_test == 8'd4) begin
      rng = xorshift(rng);
      resp_ready <= (rng[1:0] == 2'b00);
    end else begin
      resp_ready <= 1'b1;
    end
  end

  // *************************************************************************
  // Stimulus
  // *************************************************************************

  task automatic load_stim(output int count);
    int    fd;
    string line;
    count = 0;
    fd = $fopen("sim/sram_stim.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd) && count < max_cmds) begin
        line = "";
        void'($fgets(line, fd));
        if (line.getc(0) != "#" &&
            $sscanf(line, "%d %h %h %h %h %h %h %h", stim_test[count], stim_op[count],
                    stim_addr[count], stim_data[count], stim_strb[count], stim_meta[count],
                    stim_last[count], stim_exp[count]) == 8) begin
          count++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic send_cmd(input int i);
    cmd_valid   <= 1'b1;
    cmd_wr_en   <= stim_op[i][0];
    cmd_addr    <= stim_addr[i][sram_cfg_pkg::sram_addr_width-1:0];
    cmd_wr_data <= stim_data[i][sram_cfg_pkg::sram_data_width-1:0];
    cmd_wr_strb <= stim_strb[i][sram_cfg_pkg::sram_strb_width-1:0];
    cmd_meta    <= stim_meta[i][sram_cfg_pkg::sram_meta_width-1:0];
    cmd_last    <= stim_last[i][0];
    cur_test    <= stim_test[i][7:0];
    exp_data    <= stim_exp[i][sram_cfg_pkg::sram_data_width-1:0];
    @(posedge clk);
    while (!cmd_ready) begin
      @(posedge clk);
    end
  endtask

  task automatic wait_drained();
    cmd_valid <= 1'b0;
    @(posedge clk);
    while (!drained) begin
      @(posedge clk);
    end
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    cmd_valid = 1'b0;
    cmd_addr = '0;
    cmd_meta = '0;
    cmd_last = 1'b0;
    cmd_wr_en = 1'b0;
    cmd_wr_data = '0;
    cmd_wr_strb = '0;
    resp_ready = 1'b1;
    cur_test = 8'd1;
    exp_data = '0;
    rng = seed;
    load_stim(n_cmds);
    if (n_cmds == 0) begin
      $display("No commands could be read from sim/sram_stim.txt");
      $display("Simulation failed");
      $finish;
    end else begin
      cycle_limit = 3 * n_cmds * 2 + timeout_margin;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      repeat (4) @(posedge clk);  // Idle cycles checked as test 1.
      for (int i = 0; i < n_cmds; i++) begin
        if (i > 0 && stim_test[i] != stim_test[i-1]) begin
          wait_drained();
        end
        send_cmd(i);
      end
      wait_drained();
      repeat (2) @(posedge clk);
      $display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
               pass_count, fail_count, dut0.ctrl0.props0.fail_count);
      if (fail_count == 0 && dut0.ctrl0.props0.fail_count == 0) begin
        $display("Simulation completed successfully");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

  initial begin
    wait (cycle_limit > 0);
    repeat (cycle_limit) @(posedge clk);
    $display("Simulation timed out after %0d cycles with responses missing", cycle_limit);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: sim/sram_stim.txt
# test op addr wr_data strb meta last exp_rd_data
# test is decimal, the rest hex; op 1 is a write, 0 a read.
2 1 a000 d0 1 b 0 00
2 0 a000 00 0 c 1 d0
3 1 0010 5a 1 1 0 00
3 1 0010 a5 0 2 0 00
3 0 0010 00 0 3 1 5a
4 1 0100 11 1 0 0 00
4 1 0101 22 1 1 0 00
4 0 0100 00 0 2 0 11
4 1 0102 33 1 3 0 00
4 0 0101 00 0 4 0 22
4 0 0102 00 0 5 0 33
4 1 0100 44 1 6 0 00
4 0 0100 00 0 7 0 44
4 1 0103 55 0 8 0 00
4 0 a000 00 0 9 0 d0
4 1 0103 66 1 a 0 00
4 0 0103 00 0 b 1 66
5 1 a000 c0 1 0 0 00
5 1 a001 c1 1 1 0 00
5 1 a002 c2 1 2 0 00
5 1 a003 c3 1 3 0 00
5 1 a004 c4 1 4 0 00
5 1 a005 c5 1 5 0 00
5 1 a006 c6 1 6 0 00
5 1 a007 c7 1 7 0 00
5 1 a008 c8 1 8 0 00
5 1 a009 c9 1 9 0 00
5 1 a00a ca 1 a 0 00
5 1 a00b cb 1 b 0 00
5 1 a00c cc 1 c 0 00
5 1 a00d cd 1 d 0 00
5 1 a00e ce 1 e 0 00
5 1 a00f cf 1 f 0 00
5 0 a000 00 0 0 0 c0
5 0 a001 00 0 1 0 c1
5 0 a002 00 0 2 0 c2
5 0 a003 00 0 3 0 c3
5 0 a004 00 0 4 0 c4
5 0 a005 00 0 5 0 c5
5 0 a006 00 0 6 0 c6
5 0 a007 00 0 7 0 c7
5 0 a008 00 0 8 0 c8
5 0 a009 00 0 9 0 c9
5 0 a00a 00 0 a 0 ca
5 0 a00b 00 0 b 0 cb
5 0 a00c 00 0 c 0 cc
5 0 a00d 00 0 d 0 cd
5 0 a00e 00 0 e 0 ce
5 0 a00f 00 0 f 1 cf

// File: compile.f
design/sram_cfg_pkg.sv
design/sram_op_pkg.sv
design/sram_if.sv
design/sram_cmd_skid.sv
design/sram_io_ctrl.sv
design/sram_resp_fifo.sv
design/sram_subsys_top.sv
sim/sram_model.sv
sim/sram_checker.sv
sim/sram_properties.sv
sim/sram_tb.sv

// File: Bender.yml
package:
  name: sram_subsys

sources:
  - files:
      - design/sram_cfg_pkg.sv
      - design/sram_op_pkg.sv
      - design/sram_if.sv
      - design/sram_cmd_skid.sv
      - design/sram_io_ctrl.sv
      - design/sram_resp_fifo.sv
      - design/sram_subsys_top.sv
  - target: simulation
    files:
      - sim/sram_model.sv
      - sim/sram_checker.sv
      - sim/sram_properties.sv
      - sim/sram_tb.sv
